//--- Makefile
# Verilator flow for the packet unpacker

VERILATOR ?= verilator
TOP       ?= tb_b_unpacket
RTL_TOP   ?= b_unpacket_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
rtl/unpack_pkg.sv
rtl/payload_if.sv
rtl/unpack_ctrl.sv
rtl/rx_bram_reader.sv
rtl/payload_router.sv
rtl/randombit_packer.sv
rtl/b_unpacket_top.sv
verif/unpack_assertions.sv
verif/unpack_checker.sv
verif/tb_b_unpacket.sv

//--- rtl/b_unpacket_top.sv
`timescale 1ns/1ps

module b_unpacket_top #(
    parameter int PACKETS_PER_BANK = 32,
    parameter int EV_ADDR_WIDTH    = 14
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     msg_accessed,
    input  logic                     busy_net_rx,
    input  logic                     er_full,
    input  logic                     decoy_full,
    input  logic                     reset_ev,
    input  unpack_pkg::word_t        rx_bram_dout,
    output logic                     busy_rx,
    output unpack_pkg::rx_addr_t     rx_bram_addr,
    output logic                     er_wr_en,
    output unpack_pkg::word_t        er_wr_data,
    output logic                     decoy_wr_en,
    output unpack_pkg::word_t        decoy_wr_data,
    output logic                     ev_we,
    output logic [EV_ADDR_WIDTH-1:0] ev_addr,
    output unpack_pkg::rand_word_t   ev_data,
    output logic                     ev_full
);

    logic capture_header;
    logic start_stream;
    logic stream_done;
    logic clear;

    payload_if beats ();

    unpack_ctrl u_unpack_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .msg_accessed   (msg_accessed),
        .busy_net_rx    (busy_net_rx),
        .er_full        (er_full),
        .decoy_full     (decoy_full),
        .stream_done    (stream_done),
        .busy_rx        (busy_rx),
        .capture_header (capture_header),
        .start_stream   (start_stream),
        .clear          (clear)
    );

    rx_bram_reader u_rx_bram_reader (
        .clk            (clk),
        .rst_n          (rst_n),
        .capture_header (capture_header),
        .start_stream   (start_stream),
        .clear          (clear),
        .rx_bram_dout   (rx_bram_dout),
        .rx_bram_addr   (rx_bram_addr),
        .stream_done    (stream_done),
        .beats          (beats)
    );

    payload_router u_payload_router (
        .clk           (clk),
        .rst_n         (rst_n),
        .beats         (beats),
        .er_wr_en      (er_wr_en),
        .er_wr_data    (er_wr_data),
        .decoy_wr_en   (decoy_wr_en),
        .decoy_wr_data (decoy_wr_data)
    );

    randombit_packer #(
        .PACKETS_PER_BANK (PACKETS_PER_BANK),
        .EV_ADDR_WIDTH    (EV_ADDR_WIDTH)
    ) u_randombit_packer (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (clear),
        .reset_ev (reset_ev),
        .beats    (beats),
        .ev_we    (ev_we),
        .ev_addr  (ev_addr),
        .ev_data  (ev_data),
        .ev_full  (ev_full)
    );

endmodule

//--- rtl/payload_if.sv
`timescale 1ns/1ps

interface payload_if;
    logic                  valid;
    unpack_pkg::word_t     data;
    unpack_pkg::pkt_type_e pkt_type;
    // Header beat
    logic                  first;
    // Final payload beat
    logic                  last;

    modport source (
        output valid, data, pkt_type, first, last
    );

    modport sink (
        input valid, data, pkt_type, first, last
    );

endinterface

//--- rtl/payload_router.sv
`timescale 1ns/1ps

module payload_router (
    input  logic              clk,
    input  logic              rst_n,
    payload_if.sink           beats,
    output logic              er_wr_en,
    output unpack_pkg::word_t er_wr_data,
    output logic              decoy_wr_en,
    output unpack_pkg::word_t decoy_wr_data
);

    logic er_hit;
    logic decoy_hit;

    // Reconciliation keeps its header and decoy drops it
    assign er_hit = beats.valid &&
                    ((beats.pkt_type == unpack_pkg::TYPE_ER_PARITY) ||
                     (beats.pkt_type == unpack_pkg::TYPE_ER_HASHTAG));

    assign decoy_hit = beats.valid && !beats.first &&
                       (beats.pkt_type == unpack_pkg::TYPE_Z_DECOY);

    // One register stage before the FIFOs for timing slack
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            er_wr_en      <= 1'b0;
            er_wr_data    <= '0;
            decoy_wr_en   <= 1'b0;
            decoy_wr_data <= '0;
        end else begin
            er_wr_en      <= er_hit;
            er_wr_data    <= er_hit ? beats.data : '0;
            decoy_wr_en   <= decoy_hit;
            decoy_wr_data <= decoy_hit ? beats.data : '0;
        end
    end

endmodule

//--- rtl/randombit_packer.sv
`timescale 1ns/1ps

module randombit_packer #(
    parameter int PACKETS_PER_BANK = 32,
    parameter int EV_ADDR_WIDTH    = 14
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     clear,
    input  logic                     reset_ev,
    payload_if.sink                  beats,
    output logic                     ev_we,
    output logic [EV_ADDR_WIDTH-1:0] ev_addr,
    output unpack_pkg::rand_word_t   ev_data,
    output logic                     ev_full
);

    localparam int CNT_W = $clog2(PACKETS_PER_BANK + 1);

    logic              is_ev;
    logic              ev_beat;
    logic              pair_sel;
    unpack_pkg::word_t hold_q;
    logic [CNT_W-1:0]  pkt_cnt;

    assign is_ev   = (beats.pkt_type == unpack_pkg::TYPE_EV_RANDOMBIT);
    assign ev_beat = beats.valid && !beats.first && is_ev;

    // Odd trailing word is lost when clear drops the pair select
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            pair_sel <= 1'b0;
            ev_we    <= 1'b0;
        end else begin
            ev_we <= ev_beat && pair_sel;
            if (ev_beat) begin
                pair_sel <= !pair_sel;
            end
        end
    end

    // Earlier word goes to the upper half
    always_ff @(posedge clk) begin
        if (ev_beat && !pair_sel) begin
            hold_q <= beats.data;
        end
        if (ev_beat && pair_sel) begin
            ev_data <= {hold_q, beats.data};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || reset_ev) begin
            ev_addr <= '0;
        end else if (ev_we) begin
            ev_addr <= ev_addr + EV_ADDR_WIDTH'(1);
        end
    end

    // Bank fill count saturates at full
    always_ff @(posedge clk) begin
        if (!rst_n || reset_ev) begin
            pkt_cnt <= '0;
        end else if (beats.valid && beats.last && is_ev &&
                     (pkt_cnt != CNT_W'(PACKETS_PER_BANK))) begin
            pkt_cnt <= pkt_cnt + CNT_W'(1);
        end
    end

    assign ev_full = (pkt_cnt == CNT_W'(PACKETS_PER_BANK));

endmodule

//--- rtl/rx_bram_reader.sv
`timescale 1ns/1ps

module rx_bram_reader (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 capture_header,
    input  logic                 start_stream,
    input  logic                 clear,
    input  unpack_pkg::word_t    rx_bram_dout,
    output unpack_pkg::rx_addr_t rx_bram_addr,
    output logic                 stream_done,
    payload_if.source            beats
);

    localparam int LAT = unpack_pkg::RX_READ_LATENCY;

    unpack_pkg::word_t      din_q;
    unpack_pkg::word_t      header_q;
    unpack_pkg::len_code_t  len_code;
    unpack_pkg::short_len_t short_len;
    unpack_pkg::pkt_len_t   pkt_len;
    unpack_pkg::rx_addr_t   addr_q;
    logic                   issuing;
    logic                   issue_last;
    logic [LAT-1:0]         valid_pipe;
    logic [LAT-1:0]         last_pipe;

    // Input register on the RAM output
    always_ff @(posedge clk) begin
        din_q <= rx_bram_dout;
    end

    // Address 0 sits on the bus while idle, so the header is ready here
    always_ff @(posedge clk) begin
        if (capture_header) begin
            header_q <= din_q;
        end
    end

    assign len_code  = header_q[unpack_pkg::LEN_CODE_MSB:unpack_pkg::LEN_CODE_LSB];
    assign short_len = header_q[unpack_pkg::SHORT_LEN_MSB:unpack_pkg::SHORT_LEN_LSB];

    always_comb begin
        case (len_code)
            unpack_pkg::LEN_CODE_SHORT: begin
                // A zero short length still carries one word
                if (short_len == '0) begin
                    pkt_len = unpack_pkg::pkt_len_t'(1);
                end else begin
                    pkt_len = unpack_pkg::pkt_len_t'(short_len);
                end
            end
            unpack_pkg::LEN_CODE_512: pkt_len = unpack_pkg::pkt_len_t'(512);
            unpack_pkg::LEN_CODE_768: pkt_len = unpack_pkg::pkt_len_t'(768);
            default:                  pkt_len = unpack_pkg::pkt_len_t'(1024);
        endcase
    end

    // Payload addresses 1..N at one per cycle
    assign issue_last = issuing && (addr_q == pkt_len);

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            addr_q  <= '0;
            issuing <= 1'b0;
        end else if (start_stream) begin
            addr_q  <= unpack_pkg::rx_addr_t'(1);
            issuing <= 1'b1;
        end else if (issue_last) begin
            addr_q  <= '0;
            issuing <= 1'b0;
        end else if (issuing) begin
            addr_q <= addr_q + unpack_pkg::rx_addr_t'(1);
        end
    end

    assign rx_bram_addr = addr_q;

    // Tracks reads in flight through RAM and input register
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            valid_pipe <= '0;
            last_pipe  <= '0;
        end else begin
            valid_pipe <= {valid_pipe[LAT-2:0], issuing};
            last_pipe  <= {last_pipe[LAT-2:0], issue_last};
        end
    end

    assign beats.valid    = start_stream | valid_pipe[LAT-1];
    assign beats.first    = start_stream;
    assign beats.last     = last_pipe[LAT-1];
    assign beats.data     = start_stream ? header_q : din_q;
    assign beats.pkt_type =
        unpack_pkg::pkt_type_e'(header_q[unpack_pkg::TYPE_MSB:unpack_pkg::TYPE_LSB]);

    assign stream_done = last_pipe[LAT-1];

endmodule

//--- rtl/unpack_ctrl.sv
`timescale 1ns/1ps

module unpack_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic msg_accessed,
    input  logic busy_net_rx,
    input  logic er_full,
    input  logic decoy_full,
    input  logic stream_done,
    output logic busy_rx,
    output logic capture_header,
    output logic start_stream,
    output logic clear
);

    unpack_pkg::unpack_state_e state;
    unpack_pkg::unpack_state_e state_next;
    logic                      start_ok;

    // FIFO room is only checked at packet start
    assign start_ok = msg_accessed && !busy_net_rx && !er_full && !decoy_full;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= unpack_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            unpack_pkg::IDLE: begin
                if (start_ok) begin
                    state_next = unpack_pkg::READ_HEADER;
                end
            end
            unpack_pkg::READ_HEADER: state_next = unpack_pkg::SET_PARAM;
            unpack_pkg::SET_PARAM:   state_next = unpack_pkg::STREAM;
            unpack_pkg::STREAM: begin
                if (stream_done) begin
                    state_next = unpack_pkg::DONE;
                end
            end
            unpack_pkg::DONE:        state_next = unpack_pkg::WAIT_RELEASE;
            unpack_pkg::WAIT_RELEASE: begin
                // Hold until the network side takes the message back
                if (!msg_accessed) begin
                    state_next = unpack_pkg::IDLE;
                end
            end
            default: state_next = unpack_pkg::IDLE;
        endcase
    end

    assign busy_rx        = (state != unpack_pkg::IDLE);
    assign capture_header = (state == unpack_pkg::READ_HEADER);
    assign start_stream   = (state == unpack_pkg::SET_PARAM);
    assign clear          = (state == unpack_pkg::DONE);

endmodule

//--- rtl/unpack_pkg.sv
package unpack_pkg;

    // Data path widths
    typedef logic [31:0] word_t;
    typedef logic [10:0] rx_addr_t;
    typedef logic [10:0] pkt_len_t;
    typedef logic [63:0] rand_word_t;

    // Header word 0 layout
    localparam int TYPE_MSB      = 31;
    localparam int TYPE_LSB      = 28;
    localparam int LEN_CODE_MSB  = 27;
    localparam int LEN_CODE_LSB  = 24;
    localparam int SHORT_LEN_MSB = 23;
    localparam int SHORT_LEN_LSB = 15;

    typedef enum logic [3:0] {
        TYPE_ER_PARITY    = 4'd1,
        TYPE_ER_HASHTAG   = 4'd2,
        TYPE_Z_DECOY      = 4'd3,
        TYPE_EV_RANDOMBIT = 4'd4
    } pkt_type_e;

    typedef logic [3:0] len_code_t;
    typedef logic [SHORT_LEN_MSB-SHORT_LEN_LSB:0] short_len_t;

    localparam len_code_t LEN_CODE_SHORT = 4'd0;
    localparam len_code_t LEN_CODE_512   = 4'd1;
    localparam len_code_t LEN_CODE_768   = 4'd2;

    typedef enum logic [2:0] {
        IDLE,
        READ_HEADER,
        SET_PARAM,
        STREAM,
        DONE,
        WAIT_RELEASE
    } unpack_state_e;

    // RAM read cycle plus the input register
    localparam int RX_READ_LATENCY = 2;

endpackage

//--- verif/tb_b_unpacket.sv
`timescale 1ns/1ps

module tb_b_unpacket;

    localparam int EV_ADDR_WIDTH = 14;
    localparam int DRIVE_DELAY   = 2;
    localparam int WAIT_LIMIT    = 3000;

    logic                     clk;
    logic                     rst_n;
    logic                     msg_accessed;
    logic                     busy_net_rx;
    logic                     er_full;
    logic                     decoy_full;
    logic                     reset_ev;
    logic                     busy_rx;
    logic                     er_wr_en;
    logic                     decoy_wr_en;
    logic                     ev_we;
    logic                     ev_full;
    unpack_pkg::word_t        rx_bram_dout = '0;
    unpack_pkg::rx_addr_t     rx_bram_addr;
    unpack_pkg::word_t        er_wr_data;
    unpack_pkg::word_t        decoy_wr_data;
    logic [EV_ADDR_WIDTH-1:0] ev_addr;
    unpack_pkg::rand_word_t   ev_data;

    unpack_pkg::word_t        rx_ram [0:2047];
    logic [31:0]              lfsr_q;
    logic [EV_ADDR_WIDTH-1:0] ev_addr_model;
    int                       timeouts;
    int                       total;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // RX block RAM with one cycle of read latency
    always @(posedge clk) begin
        rx_bram_dout <= rx_ram[rx_bram_addr];
    end

    b_unpacket_top #(
        .PACKETS_PER_BANK (4),
        .EV_ADDR_WIDTH    (EV_ADDR_WIDTH)
    ) u_b_unpacket_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .msg_accessed  (msg_accessed),
        .busy_net_rx   (busy_net_rx),
        .er_full       (er_full),
        .decoy_full    (decoy_full),
        .reset_ev      (reset_ev),
        .rx_bram_dout  (rx_bram_dout),
        .busy_rx       (busy_rx),
        .rx_bram_addr  (rx_bram_addr),
        .er_wr_en      (er_wr_en),
        .er_wr_data    (er_wr_data),
        .decoy_wr_en   (decoy_wr_en),
        .decoy_wr_data (decoy_wr_data),
        .ev_we         (ev_we),
        .ev_addr       (ev_addr),
        .ev_data       (ev_data),
        .ev_full       (ev_full)
    );

    unpack_checker #(
        .EV_ADDR_WIDTH (EV_ADDR_WIDTH)
    ) u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .er_wr_en      (er_wr_en),
        .er_wr_data    (er_wr_data),
        .decoy_wr_en   (decoy_wr_en),
        .decoy_wr_data (decoy_wr_data),
        .ev_we         (ev_we),
        .ev_addr       (ev_addr),
        .ev_data       (ev_data)
    );

    bind b_unpacket_top unpack_assertions u_unpack_assertions (
        .clk         (clk),
        .rst_n       (rst_n),
        .busy_rx     (busy_rx),
        .er_wr_en    (er_wr_en),
        .decoy_wr_en (decoy_wr_en),
        .ev_we       (ev_we)
    );

    // Galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic random_word(output unpack_pkg::word_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w      = {w[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // Payload length from the header's length code
    function automatic int expected_len(input unpack_pkg::word_t header);
        unpack_pkg::len_code_t code;
        logic [8:0]            short_len;
        code      = header[unpack_pkg::LEN_CODE_MSB:unpack_pkg::LEN_CODE_LSB];
        short_len = header[unpack_pkg::SHORT_LEN_MSB:unpack_pkg::SHORT_LEN_LSB];
        case (code)
            unpack_pkg::LEN_CODE_SHORT: return (short_len == 9'd0) ? 1 : int'(short_len);
            unpack_pkg::LEN_CODE_512:   return 512;
            unpack_pkg::LEN_CODE_768:   return 768;
            default:                    return 1024;
        endcase
    endfunction

    task automatic push_expected(input unpack_pkg::word_t header, input int n);
        case (header[unpack_pkg::TYPE_MSB:unpack_pkg::TYPE_LSB])
            unpack_pkg::TYPE_ER_PARITY, unpack_pkg::TYPE_ER_HASHTAG: begin
                for (int i = 0; i <= n; i++) begin
                    u_checker.expect_er(rx_ram[unpack_pkg::rx_addr_t'(i)]);
                end
            end
            unpack_pkg::TYPE_Z_DECOY: begin
                for (int i = 1; i <= n; i++) begin
                    u_checker.expect_decoy(rx_ram[unpack_pkg::rx_addr_t'(i)]);
                end
            end
            unpack_pkg::TYPE_EV_RANDOMBIT: begin
                // Only full pairs are written and a trailing odd word is lost
                for (int i = 1; i + 1 <= n; i += 2) begin
                    u_checker.expect_ev(ev_addr_model,
                                        {rx_ram[unpack_pkg::rx_addr_t'(i)],
                                         rx_ram[unpack_pkg::rx_addr_t'(i + 1)]});
                    ev_addr_model = ev_addr_model + EV_ADDR_WIDTH'(1);
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic wait_busy(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (busy_rx !== level && cycles < WAIT_LIMIT) begin
            step_cycles(1);
            cycles++;
        end
        if (busy_rx !== level) begin
            timeouts++;
            $display("timeout at %0t while waiting for %s", $time, what);
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (u_checker.pending() != 0 && cycles < WAIT_LIMIT) begin
            step_cycles(1);
            cycles++;
        end
        if (u_checker.pending() != 0) begin
            timeouts++;
            $display("timeout at %0t with %0d expected writes missing",
                     $time, u_checker.pending());
        end
    endtask

    // Argument block holds er_full (1), decoy_full (2) or busy_net_rx (3) high at start
    task automatic send_packet(input logic [3:0] ptype, input unpack_pkg::len_code_t code,
                               input logic [8:0] short_len, input int block);
        unpack_pkg::word_t header;
        unpack_pkg::word_t w;
        int                n;
        random_word(header);
        header[unpack_pkg::TYPE_MSB:unpack_pkg::TYPE_LSB]           = ptype;
        header[unpack_pkg::LEN_CODE_MSB:unpack_pkg::LEN_CODE_LSB]   = code;
        header[unpack_pkg::SHORT_LEN_MSB:unpack_pkg::SHORT_LEN_LSB] = short_len;
        n         = expected_len(header);
        rx_ram[0] = header;
        for (int i = 1; i <= n; i++) begin
            random_word(w);
            rx_ram[unpack_pkg::rx_addr_t'(i)] = w;
        end
        // Header has to pass RAM and input register before start
        step_cycles(3);
        er_full      = (block == 1);
        decoy_full   = (block == 2);
        busy_net_rx  = (block == 3);
        msg_accessed = 1'b1;
        if (block != 0) begin
            for (int c = 0; c < 8; c++) begin
                step_cycles(1);
                u_checker.expect_level("busy_rx", 1'b0, busy_rx);
            end
        end
        push_expected(header, n);
        er_full     = 1'b0;
        decoy_full  = 1'b0;
        busy_net_rx = 1'b0;
        wait_busy(1'b1, "busy_rx to rise");
        wait_drain();
        msg_accessed = 1'b0;
        wait_busy(1'b0, "busy_rx to fall");
    endtask

    initial begin
        rst_n         = 1'b0;
        msg_accessed  = 1'b0;
        busy_net_rx   = 1'b0;
        er_full       = 1'b0;
        decoy_full    = 1'b0;
        reset_ev      = 1'b0;
        lfsr_q        = 32'h0ae3_2933;
        ev_addr_model = '0;
        timeouts      = 0;
        for (int a = 0; a < 2048; a++) begin
            rx_ram[a] = 32'h5a00_0000 ^ (32'(a) << 4) ^ 32'(a);
        end
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        step_cycles(2);

        send_packet(unpack_pkg::TYPE_ER_PARITY, unpack_pkg::LEN_CODE_SHORT, 9'd17, 0);
        send_packet(unpack_pkg::TYPE_ER_HASHTAG, unpack_pkg::LEN_CODE_512, 9'd0, 0);
        send_packet(unpack_pkg::TYPE_Z_DECOY, unpack_pkg::LEN_CODE_768, 9'd3, 0);
        send_packet(unpack_pkg::TYPE_Z_DECOY, 4'd3, 9'd3, 0);

        // Even, odd, zero-as-one, odd
        send_packet(unpack_pkg::TYPE_EV_RANDOMBIT, unpack_pkg::LEN_CODE_SHORT, 9'd6, 0);
        send_packet(unpack_pkg::TYPE_EV_RANDOMBIT, unpack_pkg::LEN_CODE_SHORT, 9'd5, 0);
        send_packet(unpack_pkg::TYPE_EV_RANDOMBIT, unpack_pkg::LEN_CODE_SHORT, 9'd0, 0);
        u_checker.expect_level("ev_full", 1'b0, ev_full);
        send_packet(unpack_pkg::TYPE_EV_RANDOMBIT, unpack_pkg::LEN_CODE_SHORT, 9'd9, 0);
        u_checker.expect_level("ev_full", 1'b1, ev_full);

        reset_ev = 1'b1;
        step_cycles(1);
        reset_ev      = 1'b0;
        ev_addr_model = '0;
        u_checker.expect_level("ev_full", 1'b0, ev_full);
        send_packet(unpack_pkg::TYPE_EV_RANDOMBIT, unpack_pkg::LEN_CODE_SHORT, 9'd4, 0);

        send_packet(unpack_pkg::TYPE_ER_PARITY, unpack_pkg::LEN_CODE_SHORT, 9'd4, 1);
        send_packet(unpack_pkg::TYPE_ER_PARITY, unpack_pkg::LEN_CODE_SHORT, 9'd4, 2);
        send_packet(unpack_pkg::TYPE_Z_DECOY, unpack_pkg::LEN_CODE_SHORT, 9'd4, 3);
        // Unknown type is read and dropped
        send_packet(4'h9, unpack_pkg::LEN_CODE_SHORT, 9'd12, 0);

        step_cycles(4);
        u_checker.report_leftovers();
        total = u_checker.mismatches + u_checker.unexpected + u_checker.leftover + timeouts
                + u_b_unpacket_top.u_unpack_assertions.failures;
        $display("errors: mismatches=%0d unexpected=%0d leftover=%0d timeouts=%0d assertions=%0d",
                 u_checker.mismatches, u_checker.unexpected, u_checker.leftover, timeouts,
                 u_b_unpacket_top.u_unpack_assertions.failures);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verif/unpack_assertions.sv
`timescale 1ns/1ps

module unpack_assertions (
    input logic clk,
    input logic rst_n,
    input logic busy_rx,
    input logic er_wr_en,
    input logic decoy_wr_en,
    input logic ev_we
);

    logic in_reset_q;
    int   failures = 0;

    // Skips the first reset edge where the registers are not yet cleared
    always_ff @(posedge clk) begin
        in_reset_q <= !rst_n;
    end

    a_one_fifo: assert property (@(posedge clk) disable iff (!rst_n)
        !(er_wr_en && decoy_wr_en))
    else begin
        failures++;
        $error("ER and decoy FIFOs written in the same cycle");
    end

    a_write_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (er_wr_en || decoy_wr_en || ev_we) |-> busy_rx)
    else begin
        failures++;
        $error("write made while busy_rx is low");
    end

    a_quiet_in_reset: assert property (@(posedge clk)
        (!rst_n && in_reset_q) |-> (!busy_rx && !er_wr_en && !decoy_wr_en && !ev_we))
    else begin
        failures++;
        $error("busy_rx or a write enable high during reset");
    end

endmodule

//--- verif/unpack_checker.sv
`timescale 1ns/1ps

module unpack_checker #(
    parameter int EV_ADDR_WIDTH = 14
) (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     er_wr_en,
    input unpack_pkg::word_t        er_wr_data,
    input logic                     decoy_wr_en,
    input unpack_pkg::word_t        decoy_wr_data,
    input logic                     ev_we,
    input logic [EV_ADDR_WIDTH-1:0] ev_addr,
    input unpack_pkg::rand_word_t   ev_data
);

    unpack_pkg::word_t        er_q[$];
    unpack_pkg::word_t        decoy_q[$];
    unpack_pkg::rand_word_t   ev_data_q[$];
    logic [EV_ADDR_WIDTH-1:0] ev_addr_q[$];
    int                       mismatches = 0;
    int                       unexpected = 0;
    int                       leftover   = 0;

    task automatic expect_er(input unpack_pkg::word_t w);
        er_q.push_back(w);
    endtask

    task automatic expect_decoy(input unpack_pkg::word_t w);
        decoy_q.push_back(w);
    endtask

    task automatic expect_ev(input logic [EV_ADDR_WIDTH-1:0] addr,
                             input unpack_pkg::rand_word_t data);
        ev_addr_q.push_back(addr);
        ev_data_q.push_back(data);
    endtask

    function automatic int pending();
        return er_q.size() + decoy_q.size() + ev_data_q.size();
    endfunction

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %0h actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic expect_level(input string name, input logic expected, input logic actual);
        compare_value(name, 64'(expected), 64'(actual));
    endtask

    task automatic report_leftovers();
        if (pending() != 0) begin
            leftover += pending();
            $display("%0d expected writes never arrived (ER %0d, decoy %0d, random-bit %0d)",
                     pending(), er_q.size(), decoy_q.size(), ev_data_q.size());
        end
    endtask

    // Outputs change on the rising edge, so look mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (er_wr_en) begin
                if (er_q.size() == 0) begin
                    unexpected++;
                    $display("unexpected ER FIFO write at %0t: %h", $time, er_wr_data);
                end else begin
                    compare_value("er_wr_data", 64'(er_q.pop_front()), 64'(er_wr_data));
                end
            end
            if (decoy_wr_en) begin
                if (decoy_q.size() == 0) begin
                    unexpected++;
                    $display("unexpected decoy FIFO write at %0t: %h", $time, decoy_wr_data);
                end else begin
                    compare_value("decoy_wr_data", 64'(decoy_q.pop_front()),
                                  64'(decoy_wr_data));
                end
            end
            if (ev_we) begin
                if (ev_data_q.size() == 0) begin
                    unexpected++;
                    $display("unexpected random-bit RAM write at %0t: address %0d",
                             $time, ev_addr);
                end else begin
                    compare_value("ev_addr", 64'(ev_addr_q.pop_front()), 64'(ev_addr));
                    compare_value("ev_data", ev_data_q.pop_front(), ev_data);
                end
            end
        end
    end

endmodule
